/* hdl/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// first instruction fetched after reset.
`define MIPS_RESET_VECTOR 32'h0000_0004

// a fetch from here ends the program.
`define MIPS_HALT_ADDR 32'h0000_0000

// word count of the on-chip RAM, indexed by address bits 9:2.
`define RAM_WORDS 256

// waitrequest cycles at the start of each access, 0 to 3.
`define RAM_WAIT_CYCLES 1

`endif

/* hdl/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;

    // primary opcodes of the supported subset.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SB      = 6'h28,
        OP_SW      = 6'h2b
    } opcode_t;

    // function field of OP_SPECIAL.
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_JR   = 6'h08,
        F_JALR = 6'h09,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        S_FETCH, S_EXEC, S_MEM, S_WB, S_HALT
    } cpu_state_t;

endpackage

/* hdl/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [4:0]      rs_addr,
    input  logic [4:0]      rt_addr,
    input  logic [4:0]      rd_addr,
    input  logic            wr_en,
    input  mips_pkg::word_t wr_data,
    output mips_pkg::word_t rs_data,
    output mips_pkg::word_t rt_data,
    output mips_pkg::word_t v0
);
    import mips_pkg::*;

    word_t regs [1:31];  // $zero has no storage.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd_addr != 5'd0) begin
            regs[rd_addr] <= wr_data;  // writes to $zero are dropped.
        end
    end

    assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];
    assign v0      = regs[2];  // $v0 for the observer.

endmodule

/* hdl/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::alu_op_t op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    output mips_pkg::word_t   result,
    output logic              zero
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};  // signed compare.
            ALU_SLL: result = b << shamt;
            ALU_SRL: result = b >> shamt;  // logical, zero fill.
            ALU_LUI: result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // equal operands under ALU_SUB, used by beq and bne.
    assign zero = (result == '0);

endmodule

/* hdl/mips_cpu.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_cpu (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            waitrequest,
    input  mips_pkg::word_t readdata,
    output mips_pkg::word_t address,
    output mips_pkg::word_t writedata,
    output logic            read,
    output logic            write,
    output logic [3:0]      byteenable,
    output logic            active,
    output mips_pkg::word_t register_v0
);
    import mips_pkg::*;

    cpu_state_t state;
    word_t      pc;        // address of the instruction being run.
    word_t      npc;       // next fetch, the delay slot after a jump.
    word_t      ir;
    word_t      result_q;  // alu result or link value.
    word_t      mdr_q;     // load data.

    opcode_t    opcode;
    funct_t     funct;
    logic [4:0] rs_addr;
    logic [4:0] rt_addr;
    logic [4:0] shamt;
    word_t      imm_sext;
    word_t      imm_zext;

    alu_op_t    alu_op;
    word_t      alu_b;
    word_t      alu_result;
    logic       alu_zero;
    word_t      rs_data;
    word_t      rt_data;

    logic       wb_en;
    logic [4:0] wb_addr;
    word_t      wb_data;
    logic       is_load;
    logic       is_store;
    logic       is_byte;
    logic       is_branch;
    logic       branch_ne;
    logic       is_jump;
    logic       link;
    logic       taken;
    word_t      branch_target;

    assign opcode   = opcode_t'(ir[31:26]);
    assign funct    = funct_t'(ir[5:0]);
    assign rs_addr  = ir[25:21];
    assign rt_addr  = ir[20:16];
    assign shamt    = ir[10:6];
    assign imm_sext = {{16{ir[15]}}, ir[15:0]};
    assign imm_zext = {16'h0000, ir[15:0]};

    // decode stays valid from execute to writeback since ir is held.
    always_comb begin
        alu_op    = ALU_ADD;
        alu_b     = rt_data;
        wb_en     = 1'b0;
        wb_addr   = ir[15:11];  // rd.
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_byte   = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jump   = 1'b0;
        link      = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                wb_en = 1'b1;
                case (funct)
                    F_ADDU:  alu_op = ALU_ADD;
                    F_SUBU:  alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_XOR:   alu_op = ALU_XOR;
                    F_SLT:   alu_op = ALU_SLT;
                    F_SLL:   alu_op = ALU_SLL;
                    F_SRL:   alu_op = ALU_SRL;
                    F_JALR: begin
                        is_jump = 1'b1;
                        link    = 1'b1;
                    end
                    F_JR: begin
                        is_jump = 1'b1;
                        wb_en   = 1'b0;
                    end
                    default: wb_en = 1'b0;  // unsupported, runs as a nop.
                endcase
            end
            OP_BEQ, OP_BNE: begin
                alu_op    = ALU_SUB;
                is_branch = 1'b1;
                branch_ne = (opcode == OP_BNE);
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
                wb_en   = 1'b1;
                wb_addr = rt_addr;
                case (opcode)
                    OP_ANDI: begin
                        alu_op = ALU_AND;
                        alu_b  = imm_zext;
                    end
                    OP_ORI: begin
                        alu_op = ALU_OR;
                        alu_b  = imm_zext;
                    end
                    OP_LUI: begin
                        alu_op = ALU_LUI;
                        alu_b  = imm_zext;
                    end
                    default: alu_b = imm_sext;
                endcase
            end
            OP_LW: begin
                alu_b   = imm_sext;
                wb_en   = 1'b1;
                wb_addr = rt_addr;
                is_load = 1'b1;
            end
            OP_SW, OP_SB: begin
                alu_b    = imm_sext;
                is_store = 1'b1;
                is_byte  = (opcode == OP_SB);
            end
            default: ;  // unknown opcode, no effect.
        endcase
    end

    assign taken         = is_branch && (alu_zero ^ branch_ne);
    assign branch_target = npc + {imm_sext[29:0], 2'b00};  // relative to the delay slot.
    assign wb_data       = is_load ? mdr_q : result_q;

    mips_regfile regfile_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rd_addr (wb_addr),
        .wr_en   (state == S_WB && wb_en),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    mips_alu alu_i (
        .op     (alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (shamt),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // avalon master, requests are held until waitrequest drops.
    assign read       = (state == S_FETCH && active) || (state == S_MEM && is_load);
    assign write      = (state == S_MEM) && is_store;
    assign address    = (state == S_MEM) ? {result_q[31:2], 2'b00} : pc;
    assign writedata  = is_byte ? {4{rt_data[7:0]}} : rt_data;  // byte on every lane.
    assign byteenable = (write && is_byte) ? (4'b0001 << result_q[1:0]) : 4'b1111;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= S_FETCH;
            pc     <= `MIPS_RESET_VECTOR;
            npc    <= `MIPS_RESET_VECTOR + 32'd4;
            active <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (!active) begin
                        active <= 1'b1;  // first clock out of reset.
                    end else if (!waitrequest) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    pc <= npc;  // delay slot runs next.
                    if (is_jump) begin
                        npc <= rs_data;
                    end else if (taken) begin
                        npc <= branch_target;
                    end else begin
                        npc <= npc + 32'd4;
                    end
                    state <= (is_load || is_store) ? S_MEM : S_WB;
                end
                S_MEM: begin
                    if (!waitrequest) begin
                        state <= S_WB;
                    end
                end
                S_WB: begin
                    if (pc == `MIPS_HALT_ADDR) begin
                        state  <= S_HALT;  // held until the next reset.
                        active <= 1'b0;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                S_HALT:  state <= S_HALT;
                default: state <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH && read && !waitrequest) begin
            ir <= readdata;
        end
        if (state == S_EXEC) begin
            result_q <= link ? npc + 32'd4 : alu_result;  // jalr links past the slot.
        end
        if (state == S_MEM && is_load && !waitrequest) begin
            mdr_q <= readdata;
        end
    end

endmodule

/* hdl/avalon_ram.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module avalon_ram (
    input  logic            clk,
    input  logic            arst_n,
    input  mips_pkg::word_t address,
    input  logic            read,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    input  logic [3:0]      byteenable,
    input  logic            load_en,
    input  logic [7:0]      load_addr,
    input  mips_pkg::word_t load_wdata,
    output logic            waitrequest,
    output mips_pkg::word_t readdata,
    output mips_pkg::word_t load_rdata
);
    import mips_pkg::*;

    localparam int         AW   = $clog2(`RAM_WORDS);
    localparam logic [1:0] WAIT = 2'(`RAM_WAIT_CYCLES);

    word_t         mem [`RAM_WORDS];
    logic [1:0]    wait_cnt;  // wait cycles spent on the current access.
    logic          request;
    logic [AW-1:0] word_idx;

    assign request     = read || write;
    assign word_idx    = address[AW+1:2];
    assign waitrequest = request && (wait_cnt != WAIT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= 2'd0;
        end else if (!request) begin
            wait_cnt <= 2'd0;
        end else if (waitrequest) begin
            wait_cnt <= wait_cnt + 2'd1;
        end else begin
            wait_cnt <= 2'd0;  // access done, next one waits again.
        end
    end

    // load port wins over the bus.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_wdata;
        end else if (write && !waitrequest) begin
            for (int i = 0; i < 4; i++) begin
                if (byteenable[i]) begin
                    mem[word_idx][8*i +: 8] <= writedata[8*i +: 8];
                end
            end
        end
    end

    assign readdata   = mem[word_idx];  // valid whenever the access completes.
    assign load_rdata = mem[load_addr];

endmodule

/* hdl/mips_system.sv */
`timescale 1ns/1ps

module mips_system (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            load_en,
    input  logic [7:0]      load_addr,
    input  mips_pkg::word_t load_wdata,
    output mips_pkg::word_t load_rdata,
    output mips_pkg::word_t register_v0,
    output logic            active
);
    import mips_pkg::*;

    // avalon bus between cpu and RAM.
    word_t      address;
    word_t      writedata;
    word_t      readdata;
    logic       read;
    logic       write;
    logic       waitrequest;
    logic [3:0] byteenable;

    mips_cpu cpu_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .address     (address),
        .writedata   (writedata),
        .read        (read),
        .write       (write),
        .byteenable  (byteenable),
        .active      (active),
        .register_v0 (register_v0)
    );

    avalon_ram ram_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_wdata  (load_wdata),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .load_rdata  (load_rdata)
    );

endmodule

/* verification/mips_system_chk.sv */
`timescale 1ns/1ps

module mips_system_chk (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 read,
    input logic                 write,
    input mips_pkg::word_t      address,
    input mips_pkg::word_t      writedata,
    input logic [3:0]           byteenable,
    input logic                 waitrequest,
    input logic                 active,
    input mips_pkg::cpu_state_t state
);
    import mips_pkg::*;

    int fail_cnt = 0;  // assertion failures so far.

    read_write_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(read && write))
        else begin
            fail_cnt++;
            $error("read and write are high together");
        end

    // fetch, lw and sw use whole words.
    word_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (read || (write && byteenable == 4'b1111)) |-> address[1:0] == 2'b00)
        else begin
            fail_cnt++;
            $error("word request is not word aligned");
        end

    request_held: assert property (@(posedge clk) disable iff (!arst_n)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write) &&
            $stable(writedata) && $stable(byteenable))
        else begin
            fail_cnt++;
            $error("request changed while waitrequest was high");
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        state == S_HALT |=> state == S_HALT && !active)
        else begin
            fail_cnt++;
            $error("core left the halted state before reset");
        end

endmodule

bind mips_cpu mips_system_chk chk_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .read        (read),
    .write       (write),
    .address     (address),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .waitrequest (waitrequest),
    .active      (active),
    .state       (state)
);

/* verification/mips_system_tb.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_system_tb;
    import mips_pkg::*;

    logic       clk;
    logic       arst_n;
    logic       load_en;
    logic [7:0] load_addr;
    word_t      load_wdata;
    word_t      load_rdata;
    word_t      register_v0;
    logic       active;

    word_t  img [`RAM_WORDS];    // image loaded into the RAM.
    word_t  m_mem [`RAM_WORDS];  // model memory after the run.
    word_t  m_reg [32];          // model register file.
    longint deadline = 100;      // watchdog limit in cycles that grows with each program.
    longint cycles = 0;

    mips_system mips_system_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_wdata  (load_wdata),
        .load_rdata  (load_rdata),
        .register_v0 (register_v0),
        .active      (active)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "first error ends the run");
    endtask

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (mips_system_i.cpu_i.chk_i.fail_cnt != 0) begin
                fail_run("an assertion of the bus checker failed");
            end
            if (cycles > deadline) begin
                fail_run($sformatf("timeout: the DUT did not finish within %0d cycles", cycles));
            end
        end
    end

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at time %0t: %s got %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at time %0t: %s got %b, expected %b",
                               $time, name, got, exp));
        end
    endtask

    function automatic word_t enc_r(funct_t fn, logic [4:0] rs, logic [4:0] rt,
                                    logic [4:0] rd, logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, logic [4:0] rs, logic [4:0] rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // instruction set interpreter that runs one instruction per loop pass.
    task automatic run_model(output int n);
        word_t      pc;
        word_t      npc;
        word_t      nxt;
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      sext;
        word_t      ea;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sh;
        pc    = `MIPS_RESET_VECTOR;
        npc   = pc + 32'd4;
        n     = 0;
        m_mem = img;
        foreach (m_reg[i]) m_reg[i] = '0;
        while (pc != `MIPS_HALT_ADDR && n < 4000) begin
            ins  = m_mem[pc[9:2]];
            a    = m_reg[ins[25:21]];
            b    = m_reg[ins[20:16]];
            rt   = ins[20:16];
            rd   = ins[15:11];
            sh   = ins[10:6];
            sext = {{16{ins[15]}}, ins[15:0]};
            ea   = a + sext;
            nxt  = npc + 32'd4;
            case (opcode_t'(ins[31:26]))
                OP_SPECIAL: begin
                    case (funct_t'(ins[5:0]))
                        F_ADDU: m_reg[rd] = a + b;
                        F_SUBU: m_reg[rd] = a - b;
                        F_AND:  m_reg[rd] = a & b;
                        F_OR:   m_reg[rd] = a | b;
                        F_XOR:  m_reg[rd] = a ^ b;
                        F_SLT:  m_reg[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        F_SLL:  m_reg[rd] = b << sh;
                        F_SRL:  m_reg[rd] = b >> sh;
                        F_JR:   nxt = a;
                        F_JALR: begin
                            nxt       = a;
                            m_reg[rd] = pc + 32'd8;  // return lands past the delay slot.
                        end
                        default: ;
                    endcase
                end
                OP_BEQ:   if (a == b) nxt = pc + 32'd4 + (sext << 2);
                OP_BNE:   if (a != b) nxt = pc + 32'd4 + (sext << 2);
                OP_ADDIU: m_reg[rt] = a + sext;
                OP_ANDI:  m_reg[rt] = a & {16'h0000, ins[15:0]};
                OP_ORI:   m_reg[rt] = a | {16'h0000, ins[15:0]};
                OP_LUI:   m_reg[rt] = {ins[15:0], 16'h0000};
                OP_LW:    m_reg[rt] = m_mem[ea[9:2]];
                OP_SW:    m_mem[ea[9:2]] = b;
                OP_SB:    m_mem[ea[9:2]][8*ea[1:0] +: 8] = b[7:0];
                default: ;
            endcase
            m_reg[0] = '0;
            pc       = npc;  // the delay slot always runs.
            npc      = nxt;
            n++;
        end
        if (pc != `MIPS_HALT_ADDR) begin
            fail_run("the reference model never reached the halt address");
        end
    endtask

    // call through jalr and return with jr with both delay slots filled.
    task automatic directed_program();
        foreach (img[i]) img[i] = $urandom;
        img[1]  = enc_i(OP_ADDIU, 5'd0, 5'd8, 16'h0030);  // $t0 points at the subroutine.
        img[2]  = enc_i(OP_ADDIU, 5'd0, 5'd2, 16'd3);
        img[3]  = enc_r(F_JALR, 5'd8, 5'd0, 5'd31, 5'd0);
        img[4]  = enc_r(F_SLL, 5'd0, 5'd2, 5'd2, 5'd2);
        img[5]  = enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd100);
        img[6]  = enc_r(F_JR, 5'd0, 5'd0, 5'd0, 5'd0);
        img[7]  = enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd1);
        img[12] = enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd7);
        img[13] = enc_r(F_JR, 5'd31, 5'd0, 5'd0, 5'd0);
        img[14] = enc_r(F_SLL, 5'd0, 5'd2, 5'd2, 5'd1);
    endtask

    task automatic gen_program(int len, bit mem_ops, bit branches);
        funct_t      fns [8] = '{F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_SLT, F_SLL, F_SRL};
        opcode_t     imm_ops [4] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI};
        int          kind;
        bit          prev_br;
        funct_t      fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] off;
        foreach (img[i]) img[i] = $urandom;
        prev_br = 1'b0;
        for (int w = 1; w <= len; w++) begin
            rs   = 5'($urandom_range(7));
            rt   = 5'($urandom_range(7, 1));
            rd   = 5'($urandom_range(7, 1));
            kind = $urandom_range(9);
            if (kind inside {[6:8]} && !mem_ops) begin
                kind = 4;
            end
            if (kind == 9 && (!branches || prev_br)) begin
                kind = 0;  // no branch in a delay slot.
            end
            prev_br = (kind == 9);
            case (kind)
                4, 5: img[w] = enc_i(imm_ops[$urandom_range(3)], rs, rt, 16'($urandom));
                6: img[w] = enc_i(OP_LW, 5'd0, rt, 16'(12'h300 + 4 * $urandom_range(63)));
                7: img[w] = enc_i(OP_SW, 5'd0, rt, 16'(12'h300 + 4 * $urandom_range(63)));
                8: img[w] = enc_i(OP_SB, 5'd0, rt, 16'(12'h300 + $urandom_range(255)));
                9: begin
                    off = 16'($urandom_range(len + 5 - w));  // forward offset up to the final jr.
                    if ($urandom_range(2) == 0) begin
                        rt = rs;
                    end
                    img[w] = enc_i(($urandom_range(1) == 0) ? OP_BEQ : OP_BNE, rs, rt, off);
                end
                default: begin
                    fn     = fns[$urandom_range(7)];
                    sh     = (fn == F_SLL || fn == F_SRL) ? 5'($urandom) : 5'd0;
                    img[w] = enc_r(fn, rs, rt, rd, sh);
                end
            endcase
        end
        for (int r = 3; r <= 7; r++) begin
            img[len + r - 2] = enc_r(F_XOR, 5'd2, 5'(r), 5'd2, 5'd0);  // fold into $v0.
        end
        img[len + 6] = enc_r(F_JR, 5'd0, 5'd0, 5'd0, 5'd0);
        img[len + 7] = '0;
    endtask

    // model first, then load the image while the core is held in reset.
    task automatic start_program();
        int n;
        run_model(n);
        deadline += 1000 + 20 * (1 + `RAM_WAIT_CYCLES) * n;
        @(negedge clk);
        arst_n = 1'b0;
        for (int i = 0; i < `RAM_WORDS; i++) begin
            load_en    = 1'b1;
            load_addr  = 8'(i);
            load_wdata = img[i];
            @(negedge clk);
        end
        load_en = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic finish_run();
        @(negedge clk);
        check_bit("active", active, 1'b1);
        while (active) begin
            @(negedge clk);
        end
        check_word("register_v0", register_v0, m_reg[2]);
        repeat (50) begin
            @(negedge clk);
            check_bit("active", active, 1'b0);
        end
        for (int i = 0; i < `RAM_WORDS; i++) begin
            @(negedge clk);
            load_addr = 8'(i);
            @(posedge clk);
            check_word($sformatf("mem[%0d]", i), load_rdata, m_mem[i]);
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_wdata = '0;
        void'($urandom(32'h7a8347ec));

        directed_program();
        start_program();
        finish_run();
        repeat (6) begin
            gen_program(20, 1'b0, 1'b0);
            start_program();
            finish_run();
        end
        repeat (6) begin
            gen_program(20, 1'b1, 1'b0);
            start_program();
            finish_run();
        end
        repeat (8) begin
            gen_program(24, 1'b1, 1'b1);
            start_program();
            finish_run();
        end

        // reset in the middle of a long program, then run a fresh one.
        gen_program(30, 1'b1, 1'b0);
        start_program();
        repeat (40) @(negedge clk);
        check_bit("active", active, 1'b1);
        gen_program(24, 1'b1, 1'b1);
        start_program();
        finish_run();

        if (mips_system_i.cpu_i.chk_i.fail_cnt == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run("an assertion of the bus checker failed");
        end
    end

endmodule

/* mips_system.f */
+incdir+hdl
hdl/mips_pkg.sv
hdl/mips_regfile.sv
hdl/mips_alu.sv
hdl/mips_cpu.sv
hdl/avalon_ram.sv
hdl/mips_system.sv
verification/mips_system_chk.sv
verification/mips_system_tb.sv

/* Bender.yml */
package:
  name: mips_system

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/mips_pkg.sv
      - hdl/mips_regfile.sv
      - hdl/mips_alu.sv
      - hdl/mips_cpu.sv
      - hdl/avalon_ram.sv
      - hdl/mips_system.sv
  - target: test
    files:
      - verification/mips_system_chk.sv
      - verification/mips_system_tb.sv
